//--- Bender.yml
package:
  name: cache_subsystem

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/sp_bram.sv
      - hw/sync_fifo.sv
      - hw/main_mem.sv
      - hw/dm_cache.sv
      - hw/cache_top.sv
  - target: simulation
    files:
      - sim/cache_properties.sv
      - sim/cache_tb.sv

//--- compile.f
hw/cache_pkg.sv
hw/sp_bram.sv
hw/sync_fifo.sv
hw/main_mem.sv
hw/dm_cache.sv
hw/cache_top.sv
sim/cache_properties.sv
sim/cache_tb.sv

//--- hw/cache_pkg.sv
package cache_pkg;

  // word address, 1024 words of main memory
  localparam int ADDR_BITS = 10;
  // 64 direct-mapped lines, one word each
  localparam int INDEX_BITS = 6;
  localparam int TAG_BITS = ADDR_BITS - INDEX_BITS;
  localparam int DATA_BITS = 32;
  // requester id echoed back in the response
  localparam int PROC_BITS = 2;

  // derived sizes
  localparam int LINES = 2 ** INDEX_BITS;
  localparam int MEM_WORDS = 2 ** ADDR_BITS;

  // queue depth for both request and response fifo
  localparam int FIFO_DEPTH = 4;

  // latencies in cycles
  localparam int MEM_LATENCY = 4;
  localparam int BRAM_LATENCY = 2;

  // one request from a requester
  typedef struct packed {
    logic [PROC_BITS-1:0] proc;
    logic                 write;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
  } cache_req_t;

  // one response, data is read data or the written word
  typedef struct packed {
    logic [PROC_BITS-1:0] proc;
    logic                 write;
    logic                 hit;
    logic [DATA_BITS-1:0] data;
  } cache_rsp_t;

  // access toward main memory
  typedef struct packed {
    logic                 write;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] wdata;
  } mem_req_t;

endpackage

//--- hw/cache_top.sv
`timescale 1ns/1ps

// cache subsystem top
// four-phase ports on both sides, fifos around the core
module cache_top (
  input  logic                  clk_in,
  input  logic                  rst_in,
  // request port
  input  logic                  req_in,
  input  cache_pkg::cache_req_t req_data,
  output logic                  req_ack,
  // response port
  output logic                  rsp_req,
  output cache_pkg::cache_rsp_t rsp_data,
  input  logic                  rsp_ack
);
  import cache_pkg::*;

  logic       req_push;
  logic       req_pop;
  logic       req_full;
  logic       req_empty;
  cache_req_t req_head;

  logic       rsp_push;
  logic       rsp_pop;
  logic       rsp_full;
  logic       rsp_empty;
  cache_rsp_t rsp_push_data;
  cache_rsp_t rsp_head;
  // rsp_ack seen, waiting for it to drop
  logic       rsp_wait;

  logic                 mem_req;
  mem_req_t             mem_req_data;
  logic                 mem_ack;
  logic [DATA_BITS-1:0] mem_rdata;

  // request side, enqueue on the edge that raises ack
  assign req_push = req_in && !req_ack && !req_full;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      req_ack <= 1'b0;
    end else if (req_push) begin
      req_ack <= 1'b1;
    end else if (req_ack && !req_in) begin
      req_ack <= 1'b0;
    end
  end

  // response side, next pop only after ack seen low
  assign rsp_pop = !rsp_req && !rsp_wait && !rsp_empty;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rsp_req  <= 1'b0;
      rsp_wait <= 1'b0;
    end else if (rsp_pop) begin
      rsp_req <= 1'b1;
    end else if (rsp_req && rsp_ack) begin
      rsp_req  <= 1'b0;
      rsp_wait <= 1'b1;
    end else if (rsp_wait && !rsp_ack) begin
      rsp_wait <= 1'b0;
    end
  end

  // held stable for the whole handshake
  always_ff @(posedge clk_in) begin
    if (rsp_pop) begin
      rsp_data <= rsp_head;
    end
  end

  sync_fifo #(
    .payload_t (cache_req_t),
    .DEPTH     (FIFO_DEPTH)
  ) req_fifo_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .push      (req_push),
    .push_data (req_data),
    .pop       (req_pop),
    .head      (req_head),
    .full      (req_full),
    .empty     (req_empty)
  );

  sync_fifo #(
    .payload_t (cache_rsp_t),
    .DEPTH     (FIFO_DEPTH)
  ) rsp_fifo_i (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .push      (rsp_push),
    .push_data (rsp_push_data),
    .pop       (rsp_pop),
    .head      (rsp_head),
    .full      (rsp_full),
    .empty     (rsp_empty)
  );

  dm_cache cache_i (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .req_head      (req_head),
    .req_empty     (req_empty),
    .req_pop       (req_pop),
    .rsp_full      (rsp_full),
    .rsp_push      (rsp_push),
    .rsp_push_data (rsp_push_data),
    .mem_req       (mem_req),
    .mem_req_data  (mem_req_data),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

  main_mem mem_i (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .mem_req      (mem_req),
    .mem_req_data (mem_req_data),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata)
  );

endmodule

//--- hw/dm_cache.sv
`timescale 1ns/1ps

// direct-mapped cache core, one word per line
// write-through, no allocate on write miss, refill on read miss
module dm_cache (
  input  logic                            clk_in,
  input  logic                            rst_in,
  // request fifo
  input  cache_pkg::cache_req_t           req_head,
  input  logic                            req_empty,
  output logic                            req_pop,
  // response fifo
  input  logic                            rsp_full,
  output logic                            rsp_push,
  output cache_pkg::cache_rsp_t           rsp_push_data,
  // main memory
  output logic                            mem_req,
  output cache_pkg::mem_req_t             mem_req_data,
  input  logic                            mem_ack,
  input  logic [cache_pkg::DATA_BITS-1:0] mem_rdata
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_COMPARE,
    S_MEM,
    S_DROP,
    S_RESPOND
  } state_t;

  localparam int CNT_BITS = $clog2(BRAM_LATENCY);
  localparam logic [CNT_BITS-1:0] LAT_LAST = CNT_BITS'(BRAM_LATENCY - 1);

  state_t state;
  logic [CNT_BITS-1:0] lat_cnt;

  // one valid bit per line
  logic [LINES-1:0] valid_q;

  // request in service
  cache_req_t req_q;
  // hit result kept for the late response
  logic hit_q;
  // refill word kept for the late response
  logic [DATA_BITS-1:0] fill_q;

  // address split
  logic [INDEX_BITS-1:0] idx;
  logic [TAG_BITS-1:0]   tag;

  // ram side
  logic [DATA_BITS-1:0] data_dout;
  logic [DATA_BITS-1:0] data_din;
  logic                 data_we;
  logic [TAG_BITS-1:0]  tag_dout;
  logic                 tag_we;

  logic hit;
  logic refill;

  assign idx = req_q.addr[INDEX_BITS-1:0];
  assign tag = req_q.addr[ADDR_BITS-1:INDEX_BITS];

  // only meaningful in S_COMPARE when ram outputs are valid
  assign hit = valid_q[idx] && (tag_dout == tag);

  // take a new request only with a free response slot
  // nobody else pushes, so the slot stays free until our push
  assign req_pop = (state == S_IDLE) && !req_empty && !rsp_full;

  // read miss data arriving from main memory
  assign refill = (state == S_MEM) && mem_ack && !req_q.write;

  // data ram written on refill or on a write hit
  assign data_we  = refill || ((state == S_COMPARE) && req_q.write && hit);
  assign data_din = refill ? mem_rdata : req_q.wdata;
  // tag only changes on refill, write miss leaves the line alone
  assign tag_we   = refill;

  // miss and write-through path
  assign mem_req            = (state == S_MEM);
  assign mem_req_data.write = req_q.write;
  assign mem_req_data.addr  = req_q.addr;
  assign mem_req_data.wdata = req_q.wdata;

  // read hit answers straight from compare, everything else from S_RESPOND
  assign rsp_push = ((state == S_COMPARE) && !req_q.write && hit) ||
                    (state == S_RESPOND);

  assign rsp_push_data.proc  = req_q.proc;
  assign rsp_push_data.write = req_q.write;
  assign rsp_push_data.hit   = (state == S_COMPARE) ? 1'b1 : hit_q;
  // writes echo the written word
  assign rsp_push_data.data  = req_q.write ? req_q.wdata :
                               (state == S_COMPARE) ? data_dout : fill_q;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state   <= S_IDLE;
      lat_cnt <= '0;
      valid_q <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (req_pop) begin
            state   <= S_LOOKUP;
            lat_cnt <= '0;
          end
        end
        // wait out the two ram stages
        S_LOOKUP: begin
          if (lat_cnt == LAT_LAST) begin
            state <= S_COMPARE;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        S_COMPARE: begin
          if (!req_q.write && hit) begin
            state <= S_IDLE;
          end else begin
            state <= S_MEM;
          end
        end
        // hold req until main memory acks
        S_MEM: begin
          if (mem_ack) begin
            state <= S_DROP;
            if (!req_q.write) begin
              valid_q[idx] <= 1'b1;
            end
          end
        end
        // req is low, wait for ack to fall
        S_DROP: begin
          if (!mem_ack) begin
            state <= S_RESPOND;
          end
        end
        S_RESPOND: state <= S_IDLE;
        default:   state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (req_pop) begin
      req_q <= req_head;
    end
    if (state == S_COMPARE) begin
      hit_q <= hit;
    end
    if (refill) begin
      fill_q <= mem_rdata;
    end
  end

  // line data
  sp_bram #(
    .WIDTH (DATA_BITS),
    .DEPTH (LINES)
  ) data_ram_i (
    .clk_in (clk_in),
    .addr   (idx),
    .we     (data_we),
    .din    (data_din),
    .dout   (data_dout)
  );

  // line tags
  sp_bram #(
    .WIDTH (TAG_BITS),
    .DEPTH (LINES)
  ) tag_ram_i (
    .clk_in (clk_in),
    .addr   (idx),
    .we     (tag_we),
    .din    (tag),
    .dout   (tag_dout)
  );

endmodule

//--- hw/main_mem.sv
`timescale 1ns/1ps

// slow backing store behind a four-phase req/ack port
// ack rises MEM_LATENCY+2 cycles after req is seen
module main_mem (
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  logic                          mem_req,
  input  cache_pkg::mem_req_t           mem_req_data,
  output logic                          mem_ack,
  output logic [cache_pkg::DATA_BITS-1:0] mem_rdata
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    M_IDLE,
    M_COUNT,
    M_ACCESS,
    M_PIPE,
    M_ACK
  } mstate_t;

  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);
  localparam logic [CNT_BITS-1:0] CNT_START = CNT_BITS'(MEM_LATENCY - 1);

  mstate_t state;
  logic [CNT_BITS-1:0] cnt;

  // captured access, holds the ram address steady through ack
  mem_req_t req_q;

  logic ram_we;

  // write happens in the single access cycle
  assign ram_we  = (state == M_ACCESS) && req_q.write;
  assign mem_ack = (state == M_ACK);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= M_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        M_IDLE: begin
          if (mem_req) begin
            state <= M_COUNT;
            cnt   <= CNT_START;
          end
        end
        // model the internal access delay
        M_COUNT: begin
          if (cnt == '0) begin
            state <= M_ACCESS;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        // ram sees the address, first read stage loads
        M_ACCESS: state <= M_PIPE;
        // output register loads
        M_PIPE:   state <= M_ACK;
        // hold ack until requester lets go
        M_ACK: begin
          if (!mem_req) begin
            state <= M_IDLE;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == M_IDLE && mem_req) begin
      req_q <= mem_req_data;
    end
  end

  // dout stays stable since address is held in req_q
  sp_bram #(
    .WIDTH (DATA_BITS),
    .DEPTH (MEM_WORDS)
  ) ram_i (
    .clk_in (clk_in),
    .addr   (req_q.addr),
    .we     (ram_we),
    .din    (req_q.wdata),
    .dout   (mem_rdata)
  );

endmodule

//--- hw/sp_bram.sv
`timescale 1ns/1ps

// single port block ram, read-first
// array read register plus output register, so two cycles addr to dout
module sp_bram #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 64
) (
  input  logic                     clk_in,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic                     we,
  input  logic [WIDTH-1:0]         din,
  output logic [WIDTH-1:0]         dout
);

  // storage array
  logic [WIDTH-1:0] mem [DEPTH];

  // first pipeline stage, raw array output
  logic [WIDTH-1:0] ram_q;

  // read-first: old contents come out on a write cycle
  always_ff @(posedge clk_in) begin
    ram_q <= mem[addr];
    if (we) begin
      mem[addr] <= din;
    end
  end

  // output register stage
  // high performance mode, adds the second cycle
  always_ff @(posedge clk_in) begin
    dout <= ram_q;
  end

endmodule

//--- hw/sync_fifo.sv
`timescale 1ns/1ps

// synchronous fifo, circular buffer
// payload type set per instance
module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     full,
  output logic     empty
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);
  localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(DEPTH - 1);
  localparam logic [CNT_BITS-1:0] CNT_FULL = CNT_BITS'(DEPTH);

  payload_t buffer [DEPTH];

  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS-1:0] wr_ptr;
  logic [CNT_BITS-1:0] count;

  // qualified strobes, ignore push on full and pop on empty
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == CNT_FULL);
  assign empty = (count == '0);
  // show-ahead head entry
  assign head  = buffer[rd_ptr];

  // pointers and occupancy
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // count moves only when exactly one side acts
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage write
  always_ff @(posedge clk_in) begin
    if (do_push) begin
      buffer[wr_ptr] <= push_data;
    end
  end

endmodule

//--- sim/cache_properties.sv
`timescale 1ns/1ps

// handshake checks on the cache_top ports and the miss path
module cache_properties (
  input logic                  clk_in,
  input logic                  rst_in,
  input logic                  req_in,
  input logic                  req_ack,
  input logic                  rsp_req,
  input cache_pkg::cache_rsp_t rsp_data,
  input logic                  rsp_ack,
  input logic                  mem_req,
  input cache_pkg::mem_req_t   mem_req_data,
  input logic                  mem_ack
);

  // failed assertions so far, read by the testbench
  int fail_count = 0;

  // request ack only answers a raised req_in
  assert property (@(posedge clk_in) disable iff (rst_in)
    $rose(req_ack) |-> $past(req_in))
  else begin
    $error("req_ack rose while req_in was low");
    fail_count++;
  end

  // response held with stable data until the consumer acks
  assert property (@(posedge clk_in) disable iff (rst_in)
    rsp_req && !rsp_ack |=> rsp_req && $stable(rsp_data))
  else begin
    $error("rsp_req or rsp_data changed before rsp_ack");
    fail_count++;
  end

  // miss path request payload frozen while req is up
  assert property (@(posedge clk_in) disable iff (rst_in)
    mem_req |=> !mem_req || $stable(mem_req_data))
  else begin
    $error("mem_req_data changed while mem_req was high");
    fail_count++;
  end

  assert property (@(posedge clk_in) disable iff (rst_in)
    $rose(mem_ack) |-> mem_req)
  else begin
    $error("mem_ack rose without mem_req");
    fail_count++;
  end

  // quiet handshakes through reset
  assert property (@(posedge clk_in)
    rst_in |=> !req_ack && !rsp_req && !mem_req && !mem_ack)
  else begin
    $error("handshake signal high during reset");
    fail_count++;
  end

endmodule

bind cache_top cache_properties props_i (
  .clk_in       (clk_in),
  .rst_in       (rst_in),
  .req_in       (req_in),
  .req_ack      (req_ack),
  .rsp_req      (rsp_req),
  .rsp_data     (rsp_data),
  .rsp_ack      (rsp_ack),
  .mem_req      (mem_req),
  .mem_req_data (mem_req_data),
  .mem_ack      (mem_ack)
);

//--- sim/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  localparam int          TIMEOUT_CYCLES = 1000;
  localparam logic [15:0] LFSR_SEED      = 16'd11391;

  logic       clk_in;
  logic       rst_in;
  logic       req_in;
  cache_req_t req_data;
  logic       req_ack;
  logic       rsp_req;
  cache_rsp_t rsp_data;
  logic       rsp_ack;

  // reference model, memory words and line state
  logic [DATA_BITS-1:0] mem_model [MEM_WORDS];
  logic                 line_valid [LINES];
  logic [TAG_BITS-1:0]  line_tag [LINES];
  // responses still owed, in request order
  cache_rsp_t           exp_q [$];
  // addresses known to hold data
  logic [ADDR_BITS-1:0] addr_list [8];

  logic [15:0] lfsr;
  logic        hold_ack;
  string       test_name;
  int          error_count;
  int          timeout_count;
  int          check_count;
  int          test_count;
  int          fails_at_start;

  cache_top cache_top_i (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .req_in   (req_in),
    .req_data (req_data),
    .req_ack  (req_ack),
    .rsp_req  (rsp_req),
    .rsp_data (rsp_data),
    .rsp_ack  (rsp_ack)
  );

  always #2 clk_in = ~clk_in;

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // write-through, no allocate on write, refill on read miss
  function automatic cache_rsp_t model_access(input cache_req_t r);
    cache_rsp_t            e;
    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    idx     = r.addr[INDEX_BITS-1:0];
    tag     = r.addr[ADDR_BITS-1:INDEX_BITS];
    e.proc  = r.proc;
    e.write = r.write;
    e.hit   = line_valid[idx] && (line_tag[idx] == tag);
    if (r.write) begin
      mem_model[r.addr] = r.wdata;
      e.data            = r.wdata;
    end else begin
      e.data          = mem_model[r.addr];
      line_valid[idx] = 1'b1;
      line_tag[idx]   = tag;
    end
    return e;
  endfunction

  // includes failures of the bound handshake assertions
  function automatic int total_fails();
    return error_count + timeout_count + cache_top_i.props_i.fail_count;
  endfunction

  task automatic report_timeout(input string what);
    $display("timeout in test %s: %s", test_name, what);
    timeout_count++;
  endtask

  // one full four-phase request, expected response queued first
  task automatic send_req(input logic [PROC_BITS-1:0] proc, input logic write,
                          input logic [ADDR_BITS-1:0] addr,
                          input logic [DATA_BITS-1:0] wdata);
    cache_req_t r;
    int         cnt;
    r.proc  = proc;
    r.write = write;
    r.addr  = addr;
    r.wdata = wdata;
    exp_q.push_back(model_access(r));
    @(posedge clk_in);
    req_in   <= 1'b1;
    req_data <= r;
    cnt = 0;
    while (!req_ack && cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_in);
      cnt++;
    end
    if (!req_ack) begin
      report_timeout("req_ack never rose");
    end
    req_in <= 1'b0;
    cnt = 0;
    while (req_ack && cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_in);
      cnt++;
    end
    if (req_ack) begin
      report_timeout("req_ack never fell");
    end
  endtask

  // polled on the falling edge, away from the consumer updates
  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < TIMEOUT_CYCLES) begin
      @(negedge clk_in);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      report_timeout("not every response arrived");
    end
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    fails_at_start = total_fails();
  endtask

  task automatic end_test();
    test_count++;
    $display("test %s: %0d failures", test_name, total_fails() - fails_at_start);
  endtask

  // consumer, checks each response then runs the ack handshake
  initial begin
    cache_rsp_t exp;
    rsp_ack = 1'b0;
    forever begin
      @(posedge clk_in);
      if (rsp_req && !rsp_ack && !hold_ack && !rst_in) begin
        check_count++;
        assert (exp_q.size() != 0) else begin
          $display("test %s: a response came with no request outstanding", test_name);
          error_count++;
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          assert (rsp_data == exp) else begin
            $display("Error: test %s expected %h actual %h", test_name, exp, rsp_data);
            error_count++;
          end
        end
        rsp_ack <= 1'b1;
      end else if (rsp_ack && !rsp_req) begin
        rsp_ack <= 1'b0;
      end
    end
  end

  // overall time limit
  initial begin
    #200000;
    $display("simulation time limit reached before the tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic [PROC_BITS-1:0]  p;
    logic                  w;
    logic [2:0]            k;
    logic [DATA_BITS-1:0]  d;
    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag_a;
    logic [ADDR_BITS-1:0]  addr_a;
    logic [ADDR_BITS-1:0]  addr_b;
    clk_in        = 1'b0;
    rst_in        = 1'b1;
    req_in        = 1'b0;
    req_data      = '0;
    hold_ack      = 1'b0;
    lfsr          = LFSR_SEED;
    error_count   = 0;
    timeout_count = 0;
    check_count   = 0;
    test_count    = 0;
    for (int i = 0; i < LINES; i++) begin
      line_valid[i] = 1'b0;
    end
    repeat (8) @(posedge clk_in);
    rst_in <= 1'b0;

    // write then read, fresh lines miss
    start_test("write_then_read");
    for (int i = 0; i < 8; i++) begin
      addr_list[i] = ADDR_BITS'(rand_bits(ADDR_BITS));
      p = PROC_BITS'(rand_bits(PROC_BITS));
      d = rand_bits(DATA_BITS);
      send_req(p, 1'b1, addr_list[i], d);
      send_req(p, 1'b0, addr_list[i], '0);
    end
    wait_drain();
    end_test();

    // same addresses again, now refilled
    start_test("read_again");
    for (int i = 0; i < 8; i++) begin
      send_req(PROC_BITS'(i), 1'b0, addr_list[i], '0);
    end
    wait_drain();
    end_test();

    // same index, two tags, read alternately
    start_test("conflict");
    idx    = INDEX_BITS'(rand_bits(INDEX_BITS));
    tag_a  = TAG_BITS'(rand_bits(TAG_BITS));
    addr_a = {tag_a, idx};
    addr_b = {tag_a ^ TAG_BITS'(9), idx};
    d      = rand_bits(DATA_BITS);
    send_req(2'd0, 1'b1, addr_a, d);
    send_req(2'd1, 1'b1, addr_b, ~d);
    repeat (3) begin
      send_req(2'd2, 1'b0, addr_a, '0);
      send_req(2'd3, 1'b0, addr_b, '0);
    end
    wait_drain();
    end_test();

    // cache a line, write it, read it back
    start_test("write_hit");
    d = rand_bits(DATA_BITS);
    send_req(2'd1, 1'b0, addr_list[0], '0);
    send_req(2'd2, 1'b1, addr_list[0], d);
    send_req(2'd3, 1'b0, addr_list[0], '0);
    wait_drain();
    end_test();

    // random requester tags and a read/write mix
    start_test("tag_echo");
    for (int i = 0; i < 12; i++) begin
      p = PROC_BITS'(rand_bits(PROC_BITS));
      w = rand_bits(1) != 0;
      k = 3'(rand_bits(3));
      d = rand_bits(DATA_BITS);
      send_req(p, w, addr_list[k], d);
    end
    wait_drain();
    end_test();

    // consumer stalled while the queues fill
    start_test("back_pressure");
    @(posedge clk_in);
    hold_ack <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      p = PROC_BITS'(rand_bits(PROC_BITS));
      w = rand_bits(1) != 0;
      k = 3'(rand_bits(3));
      d = rand_bits(DATA_BITS);
      send_req(p, w, addr_list[k], d);
    end
    @(posedge clk_in);
    hold_ack <= 1'b0;
    wait_drain();
    end_test();

    repeat (4) @(posedge clk_in);
    $display("tests %0d, responses checked %0d, errors %0d, timeouts %0d, assertion fails %0d",
             test_count, check_count, error_count, timeout_count,
             cache_top_i.props_i.fail_count);
    if (total_fails() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
